// ==== hw/dma_rx_pkg.sv ====
// shared widths, TLP field codes, ring and chunk defaults
// and the state encodings of the receive DMA engine

package dma_rx_pkg;

    typedef logic [8:0]  qw_len_t;                      // chunk / completion length in qwords
    typedef logic [31:0] page_len_t;                    // page length in qwords
    typedef logic [63:0] host_addr_t;                   // host byte address

    localparam logic [6:0] CPL_FMT_TYPE  = 7'b10_01010; // 3dw completion with data
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;      // successful completion
    localparam int         QW_BYTES_LOG2 = 3;           // qword count to byte offset

    // default ring and chunk ladder limits
    localparam int DEFAULT_BUF_AW       = 9;            // 512 qword ring
    localparam int DEFAULT_MAX_CHUNK_QW = 128;
    localparam int DEFAULT_MIN_CHUNK_QW = 16;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_SETTLE,                                    // sizer pipeline catching up
        CTRL_SIZE,
        CTRL_REQUEST,
        CTRL_ADVANCE,
        CTRL_CHECK
    } ctrl_state_e;

    typedef enum logic [1:0] {
        NOTE_IDLE,
        NOTE_COLLECT,
        NOTE_NOTIFY
    } note_state_e;

    typedef enum logic [1:0] {
        CPL_HEADER,
        CPL_FIRST_DATA,
        CPL_DATA
    } cpl_state_e;

endpackage

// ==== hw/chunk_if.sv ====
// controller to chunk sizer connection

`timescale 1ns/1ps

interface chunk_if import dma_rx_pkg::*; ();

    logic       load;                                   // latch a new page
    host_addr_t page_addr;
    page_len_t  page_qwords;
    logic       advance;                                // commit current chunk

    logic       chunk_ok;
    qw_len_t    chunk_qwords;
    host_addr_t rd_addr;                                // host address of next chunk
    logic       page_issued;

    modport ctrl  (output load, page_addr, page_qwords, advance,
                   input  chunk_ok, chunk_qwords, page_issued);

    modport sizer (input  load, page_addr, page_qwords, advance,
                   output chunk_ok, chunk_qwords, rd_addr, page_issued);

endinterface

// ==== hw/dma_rx_ctrl.sv ====
// page accept, read request and page notification state machines

`timescale 1ns/1ps

module dma_rx_ctrl import dma_rx_pkg::*; (
    input  logic       trn_clk,
    input  logic       reset_n,
    input  logic       page_valid,
    input  host_addr_t page_addr,
    input  page_len_t  page_qwords,
    output logic       page_free,
    output logic       read_chunk,
    output qw_len_t    qwords_to_rd,
    input  logic       read_chunk_ack,
    output logic       notify,
    output host_addr_t notification_message,
    input  logic       notify_ack,
    input  logic       cpl_done,
    input  qw_len_t    cpl_qwords,
    chunk_if.ctrl      chunk
);

    ctrl_state_e ctrl_state;
    note_state_e note_state;
    logic [1:0]  settle_cnt;
    page_len_t   note_len;                              // qwords expected for this page
    page_len_t   note_sum;                              // qwords received so far
    page_len_t   note_sum_next;

    // new page only once the previous one has been notified
    assign chunk.load = (ctrl_state == CTRL_IDLE) && page_valid && (note_state == NOTE_IDLE);
    assign chunk.page_addr   = page_addr;
    assign chunk.page_qwords = page_qwords;
    assign chunk.advance     = (ctrl_state == CTRL_ADVANCE);
    assign page_free         = (ctrl_state == CTRL_CHECK) && chunk.page_issued;

    assign note_sum_next = note_sum + page_len_t'(cpl_qwords);

    //////////////////////////////////////////////////////////////////////
    // read request machine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_state <= CTRL_IDLE;
            read_chunk <= 1'b0;
            settle_cnt <= 2'd0;
        end else begin
            case (ctrl_state)
                CTRL_IDLE: begin
                    settle_cnt <= 2'd1;
                    if (chunk.load) ctrl_state <= CTRL_SETTLE;
                end
                CTRL_SETTLE: begin
                    settle_cnt <= settle_cnt - 2'd1;
                    if (settle_cnt == 2'd0) ctrl_state <= CTRL_SIZE;
                end
                CTRL_SIZE: begin
                    if (chunk.chunk_ok) begin               // waits here for ring space
                        read_chunk <= 1'b1;
                        ctrl_state <= CTRL_REQUEST;
                    end
                end
                CTRL_REQUEST: begin
                    if (read_chunk_ack) begin
                        read_chunk <= 1'b0;
                        ctrl_state <= CTRL_ADVANCE;
                    end
                end
                CTRL_ADVANCE: ctrl_state <= CTRL_CHECK;     // sizer pointers move
                CTRL_CHECK: begin
                    settle_cnt <= 2'd1;
                    ctrl_state <= chunk.page_issued ? CTRL_IDLE : CTRL_SETTLE;
                end
                default: ctrl_state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge trn_clk) begin
        if (ctrl_state == CTRL_SIZE && chunk.chunk_ok) qwords_to_rd <= chunk.chunk_qwords;
        if (chunk.load) begin
            notification_message <= page_addr;
            note_len             <= page_qwords;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // notification machine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            note_state <= NOTE_IDLE;
            note_sum   <= '0;
            notify     <= 1'b0;
        end else begin
            case (note_state)
                NOTE_IDLE: begin
                    note_sum <= '0;
                    if (chunk.load) note_state <= NOTE_COLLECT;
                end
                NOTE_COLLECT: begin
                    if (cpl_done) begin
                        note_sum <= note_sum_next;
                        if (note_sum_next == note_len) begin    // whole page landed
                            notify     <= 1'b1;
                            note_state <= NOTE_NOTIFY;
                        end
                    end
                end
                NOTE_NOTIFY: begin
                    if (notify_ack) begin
                        notify     <= 1'b0;
                        note_state <= NOTE_IDLE;
                    end
                end
                default: note_state <= NOTE_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/chunk_sizer.sv ====
// ring occupancy, chunk size selection and page read pointers

`timescale 1ns/1ps

module chunk_sizer import dma_rx_pkg::*; #(
    parameter int BUF_AW       = DEFAULT_BUF_AW,
    parameter int MAX_CHUNK_QW = DEFAULT_MAX_CHUNK_QW,
    parameter int MIN_CHUNK_QW = DEFAULT_MIN_CHUNK_QW
) (
    input  logic              trn_clk,
    input  logic              reset_n,
    input  logic [BUF_AW-1:0] commited_rd_addr,
    chunk_if.sizer            chunk
);

    localparam int RING_LIMIT = (1 << BUF_AW) - 1;      // one slot kept free
    localparam int LADDER_N   = $clog2(MAX_CHUNK_QW) - $clog2(MIN_CHUNK_QW) + 1;

    logic [BUF_AW-1:0] wr_ptr;                          // ring slot of next requested qword
    page_len_t         page_len;
    page_len_t         page_cnt;                        // qwords requested so far
    logic [BUF_AW-1:0] occupancy;
    page_len_t         remaining;
    logic              stage_fresh;                     // stage 1 reflects current pointers
    logic              pick_ok;
    logic [31:0]       pick_qw;

    function automatic logic fits(input logic [31:0] size, input logic [BUF_AW-1:0] occ);
        return (32'(occ) + size) <= 32'(RING_LIMIT);
    endfunction

    assign chunk.page_issued = (page_cnt == page_len);

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            chunk.rd_addr <= '0;
            wr_ptr        <= '0;
            page_cnt      <= '0;
            page_len      <= '0;
        end else if (chunk.load) begin
            chunk.rd_addr <= chunk.page_addr;
            page_cnt      <= '0;
            page_len      <= chunk.page_qwords;
        end else if (chunk.advance) begin
            chunk.rd_addr <= chunk.rd_addr + (host_addr_t'(chunk.chunk_qwords) << QW_BYTES_LOG2);
            wr_ptr        <= wr_ptr + BUF_AW'(chunk.chunk_qwords);
            page_cnt      <= page_cnt + page_len_t'(chunk.chunk_qwords);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // size selection
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        pick_ok = 1'b0;
        pick_qw = '0;
        if (remaining != '0 && remaining <= page_len_t'(MAX_CHUNK_QW)
                && fits(remaining, occupancy)) begin
            pick_ok = 1'b1;
            pick_qw = remaining;
        end
        for (int i = 0; i < LADDER_N; i++) begin
            if (!pick_ok && (MAX_CHUNK_QW >> i) <= remaining
                    && fits(32'(MAX_CHUNK_QW >> i), occupancy)) begin
                pick_ok = 1'b1;
                pick_qw = 32'(MAX_CHUNK_QW >> i);
            end
        end
    end

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            occupancy          <= '0;
            remaining          <= '0;
            stage_fresh        <= 1'b0;
            chunk.chunk_ok     <= 1'b0;
            chunk.chunk_qwords <= '0;
        end else begin
            occupancy   <= wr_ptr - commited_rd_addr;       // modulo ring
            remaining   <= page_len - page_cnt;
            stage_fresh <= !(chunk.load || chunk.advance);
            if (chunk.load || chunk.advance) begin
                chunk.chunk_ok <= 1'b0;
            end else if (!chunk.chunk_ok) begin             // offer held until used
                chunk.chunk_ok     <= pick_ok && stage_fresh;
                chunk.chunk_qwords <= qw_len_t'(pick_qw);
            end
        end
    end

endmodule

// ==== hw/cpl_writer.sv ====
// completion TLP parser, payload byte swap and ring buffer writer

`timescale 1ns/1ps

module cpl_writer import dma_rx_pkg::*; #(
    parameter int BUF_AW = DEFAULT_BUF_AW
) (
    input  logic              trn_clk,
    input  logic              reset_n,
    input  logic [63:0]       trn_rd,
    input  logic              trn_rsof_n,
    input  logic              trn_reof_n,
    input  logic              trn_rsrc_rdy_n,
    input  logic              trn_rdst_rdy_n,
    output logic [BUF_AW-1:0] wr_addr,
    output logic [63:0]       wr_data,
    output logic              wr_en,
    output logic [BUF_AW-1:0] commited_wr_addr,
    output logic              cpl_done,
    output qw_len_t           cpl_qwords
);

    cpl_state_e        cpl_state;
    logic              beat;                            // a beat transfers this cycle
    logic [31:0]       dw_hold;                         // low dword waiting for its partner
    logic [BUF_AW-1:0] tail_addr;                       // next free ring slot

    function automatic logic [31:0] swap_dw(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign beat = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            cpl_state        <= CPL_HEADER;
            wr_en            <= 1'b0;
            wr_addr          <= '0;
            tail_addr        <= '0;
            commited_wr_addr <= '0;
            cpl_done         <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            cpl_done <= 1'b0;
            case (cpl_state)
                CPL_HEADER: begin
                    if (beat && !trn_rsof_n && trn_rd[62:56] == CPL_FMT_TYPE
                            && trn_rd[15:13] == CPL_STATUS_SC) begin
                        cpl_state <= CPL_FIRST_DATA;        // anything else is skipped
                    end
                end
                CPL_FIRST_DATA: begin
                    if (beat) cpl_state <= trn_reof_n ? CPL_DATA : CPL_HEADER;
                end
                CPL_DATA: begin
                    if (beat) begin
                        wr_en     <= 1'b1;
                        wr_addr   <= tail_addr;
                        tail_addr <= tail_addr + 1'b1;
                        if (!trn_reof_n) begin
                            commited_wr_addr <= tail_addr + 1'b1;
                            cpl_done         <= 1'b1;
                            cpl_state        <= CPL_HEADER;
                        end
                    end
                end
                default: cpl_state <= CPL_HEADER;
            endcase
        end
    end

    // payload path
    always_ff @(posedge trn_clk) begin
        if (cpl_state == CPL_HEADER && beat && !trn_rsof_n) cpl_qwords <= trn_rd[41:33];
        if (beat && cpl_state != CPL_HEADER) dw_hold <= trn_rd[31:0];
        if (beat && cpl_state == CPL_DATA) begin
            wr_data <= {swap_dw(trn_rd[63:32]), swap_dw(dw_hold)};
        end
    end

endmodule

// ==== hw/dma_rx_top.sv ====
// receive DMA engine top level
// controller, chunk sizer and completion writer

`timescale 1ns/1ps

module dma_rx_top import dma_rx_pkg::*; #(
    parameter int BUF_AW       = DEFAULT_BUF_AW,
    parameter int MAX_CHUNK_QW = DEFAULT_MAX_CHUNK_QW,
    parameter int MIN_CHUNK_QW = DEFAULT_MIN_CHUNK_QW
) (
    input  logic              trn_clk,
    input  logic              reset_n,

    // receive stream
    input  logic [63:0]       trn_rd,
    input  logic              trn_rsof_n,
    input  logic              trn_reof_n,
    input  logic              trn_rsrc_rdy_n,
    input  logic              trn_rdst_rdy_n,

    // page offer
    input  logic              page_valid,
    input  host_addr_t        page_addr,
    input  page_len_t         page_qwords,
    output logic              page_free,

    // read request
    output logic              read_chunk,
    output qw_len_t           qwords_to_rd,
    output host_addr_t        rd_addr,
    input  logic              read_chunk_ack,

    // notification
    output logic              notify,
    output host_addr_t        notification_message,
    input  logic              notify_ack,

    // ring buffer
    output logic [BUF_AW-1:0] wr_addr,
    output logic [63:0]       wr_data,
    output logic              wr_en,
    input  logic [BUF_AW-1:0] commited_rd_addr,
    output logic [BUF_AW-1:0] commited_wr_addr
);

    logic    cpl_done;
    qw_len_t cpl_qwords;

    chunk_if chunk_bus ();

    assign rd_addr = chunk_bus.rd_addr;

    dma_rx_ctrl u_ctrl (
        .trn_clk              (trn_clk),
        .reset_n              (reset_n),
        .page_valid           (page_valid),
        .page_addr            (page_addr),
        .page_qwords          (page_qwords),
        .page_free            (page_free),
        .read_chunk           (read_chunk),
        .qwords_to_rd         (qwords_to_rd),
        .read_chunk_ack       (read_chunk_ack),
        .notify               (notify),
        .notification_message (notification_message),
        .notify_ack           (notify_ack),
        .cpl_done             (cpl_done),
        .cpl_qwords           (cpl_qwords),
        .chunk                (chunk_bus.ctrl)
    );

    chunk_sizer #(
        .BUF_AW       (BUF_AW),
        .MAX_CHUNK_QW (MAX_CHUNK_QW),
        .MIN_CHUNK_QW (MIN_CHUNK_QW)
    ) u_sizer (
        .trn_clk          (trn_clk),
        .reset_n          (reset_n),
        .commited_rd_addr (commited_rd_addr),
        .chunk            (chunk_bus.sizer)
    );

    cpl_writer #(
        .BUF_AW (BUF_AW)
    ) u_writer (
        .trn_clk          (trn_clk),
        .reset_n          (reset_n),
        .trn_rd           (trn_rd),
        .trn_rsof_n       (trn_rsof_n),
        .trn_reof_n       (trn_reof_n),
        .trn_rsrc_rdy_n   (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n   (trn_rdst_rdy_n),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .wr_en            (wr_en),
        .commited_wr_addr (commited_wr_addr),
        .cpl_done         (cpl_done),
        .cpl_qwords       (cpl_qwords)
    );

endmodule

// ==== bench/dma_rx_assert.sv ====
// concurrent handshake and reset checks for the receive DMA top level
// bound into every dma_rx_top instance

`timescale 1ns/1ps

module dma_rx_assert import dma_rx_pkg::*; (
    input logic       trn_clk,
    input logic       reset_n,
    input logic       read_chunk,
    input logic       read_chunk_ack,
    input qw_len_t    qwords_to_rd,
    input host_addr_t rd_addr,
    input logic       notify,
    input logic       notify_ack,
    input host_addr_t notification_message,
    input logic       wr_en,
    input logic       page_free
);

    // read request holds with stable size and address until acked
    read_hold: assert property (@(posedge trn_clk) disable iff (!reset_n)
        read_chunk && !read_chunk_ack |=> read_chunk && $stable(qwords_to_rd) && $stable(rd_addr))
        else $error("read_chunk dropped or changed before ack");

    read_drop: assert property (@(posedge trn_clk) disable iff (!reset_n)
        read_chunk && read_chunk_ack |=> !read_chunk)
        else $error("read_chunk still high after ack");

    // notification holds with stable message until acked
    note_hold: assert property (@(posedge trn_clk) disable iff (!reset_n)
        notify && !notify_ack |=> notify && $stable(notification_message))
        else $error("notify dropped or changed before ack");

    note_drop: assert property (@(posedge trn_clk) disable iff (!reset_n)
        notify && notify_ack |=> !notify)
        else $error("notify still high after ack");

    reset_quiet: assert property (@(posedge trn_clk)
        $rose(reset_n) |-> !wr_en && !page_free)
        else $error("wr_en or page_free active right after reset");

endmodule

bind dma_rx_top dma_rx_assert u_assert (
    .trn_clk              (trn_clk),
    .reset_n              (reset_n),
    .read_chunk           (read_chunk),
    .read_chunk_ack       (read_chunk_ack),
    .qwords_to_rd         (qwords_to_rd),
    .rd_addr              (rd_addr),
    .notify               (notify),
    .notify_ack           (notify_ack),
    .notification_message (notification_message),
    .wr_en                (wr_en),
    .page_free            (page_free)
);

// ==== bench/dma_rx_tb.sv ====
// receive DMA testbench with clock, reset, host model,
// completion sender, ring write checks, timeout and verdict

`timescale 1ns/1ps

module dma_rx_tb import dma_rx_pkg::*; ;

    localparam int BUF_AW         = 9;
    localparam int RING           = 1 << BUF_AW;
    localparam int MAX_CHUNK_QW   = 128;
    localparam int MIN_CHUNK_QW   = 16;
    localparam int NUM_PAGES      = 3;
    localparam int TOTAL_QW       = 700 + 77 + 45;
    localparam int TIMEOUT_CYCLES = TOTAL_QW * 8 + 2000;

    logic              trn_clk;
    logic              reset_n;
    logic [63:0]       trn_rd;
    logic              trn_rsof_n;
    logic              trn_reof_n;
    logic              trn_rsrc_rdy_n;
    logic              trn_rdst_rdy_n;
    logic              page_valid;
    host_addr_t        page_addr;
    page_len_t         page_qwords;
    logic              page_free;
    logic              read_chunk;
    qw_len_t           qwords_to_rd;
    host_addr_t        rd_addr;
    logic              read_chunk_ack;
    logic              notify;
    host_addr_t        notification_message;
    logic              notify_ack;
    logic [BUF_AW-1:0] wr_addr;
    logic [63:0]       wr_data;
    logic              wr_en;
    logic [BUF_AW-1:0] commited_rd_addr;
    logic [BUF_AW-1:0] commited_wr_addr;

    host_addr_t page_base [NUM_PAGES] = '{64'h0000_0001_2340_0000, 64'h0000_0002_0000_1000,
                                          64'h0000_0000_8000_0800};
    page_len_t  page_size [NUM_PAGES] = '{32'd700, 32'd77, 32'd45};

    integer            seed = 32'h3ccb;
    int                cur_page;
    page_len_t         issued;                          // qwords requested for this page
    int                total_req;
    int                good_qw;                         // good payload qwords sent
    int                writes_seen;
    int                page_target;                     // writes needed before notify
    int                notes;
    int                frees;
    int                cycles;
    int                rem;
    int                req_size;
    int                n_qw;
    int                split;
    bit                size_ok;
    bit                junk_done;
    logic [BUF_AW-1:0] occ;
    logic [63:0]       exp_word;
    logic [63:0]       exp_data [$];
    int                req_q [$];

    dma_rx_top #(
        .BUF_AW       (BUF_AW),
        .MAX_CHUNK_QW (MAX_CHUNK_QW),
        .MIN_CHUNK_QW (MIN_CHUNK_QW)
    ) uut (.*);

    always #5 trn_clk = ~trn_clk;

    ////////////////////////////////////////////////////////////////////
    // reporting and payload helpers
    ////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expv);
        abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expv));
    endtask

    function automatic logic [31:0] byte_swap32(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    function automatic logic [31:0] payload_lo(input int g);
        return (32'(g) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] payload_hi(input int g);
        return {~16'(g), 16'(g)} ^ 32'h0ff0_1234;
    endfunction

    // one beat, held until the core takes it
    task automatic send_beat(input logic [63:0] data, input logic sof, input logic eof);
        trn_rd         <= data;
        trn_rsof_n     <= !sof;
        trn_reof_n     <= !eof;
        trn_rsrc_rdy_n <= 1'b0;
        @(posedge trn_clk);
        while (trn_rdst_rdy_n) @(posedge trn_clk);
    endtask

    task automatic send_frame(input logic [6:0] fmt, input logic [2:0] status, input int nq,
                              input int base, input bit good);
        logic [63:0] hdr;
        hdr        = '0;
        hdr[62:56] = fmt;
        hdr[41:32] = 10'(nq * 2);                       // length in dwords
        hdr[15:13] = status;
        if (good) begin
            for (int j = 0; j < nq; j++) begin
                exp_data.push_back({byte_swap32(payload_hi(base + j)),
                                    byte_swap32(payload_lo(base + j))});
            end
        end
        send_beat(hdr, 1'b1, 1'b0);
        send_beat({32'h0, payload_lo(base)}, 1'b0, 1'b0);
        for (int j = 0; j < nq; j++) begin
            send_beat({payload_hi(base + j), (j + 1 < nq) ? payload_lo(base + j + 1) : 32'h0},
                      1'b0, j == nq - 1);
        end
        trn_rsrc_rdy_n <= 1'b1;
        trn_rsof_n     <= 1'b1;
        trn_reof_n     <= 1'b1;
        if (good) good_qw += nq;
        @(posedge trn_clk);
        assert (commited_wr_addr == BUF_AW'(good_qw))
            else report_mismatch("commited_wr_addr", 64'(commited_wr_addr), 64'(good_qw));
    endtask

    ////////////////////////////////////////////////////////////////////
    // host model
    ////////////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin
        if (reset_n && read_chunk && !read_chunk_ack) begin
            req_size = int'(qwords_to_rd);
            rem      = int'(page_size[cur_page] - issued);
            occ      = BUF_AW'(total_req) - commited_rd_addr;
            size_ok  = (req_size == rem && rem <= MAX_CHUNK_QW)
                || ((req_size & (req_size - 1)) == 0 && req_size >= MIN_CHUNK_QW
                    && req_size <= MAX_CHUNK_QW && req_size <= rem);
            assert (rd_addr == page_base[cur_page] + (host_addr_t'(issued) << QW_BYTES_LOG2))
                else report_mismatch("rd_addr", rd_addr,
                                     page_base[cur_page] + (host_addr_t'(issued) << 3));
            assert (req_size != 0 && size_ok)
                else abort_run($sformatf("chunk size %0d breaks the size rule", req_size));
            assert (int'(occ) + req_size <= RING - 1)
                else abort_run("read request exceeds free ring space");
            issued         <= issued + page_len_t'(req_size);
            total_req      += req_size;
            req_q.push_back(req_size);
            read_chunk_ack <= 1'b1;
        end else begin
            read_chunk_ack <= 1'b0;
        end
    end

    // one or two completions per read request
    always begin
        @(posedge trn_clk);
        if (req_q.size() != 0) begin
            n_qw  = req_q.pop_front();
            split = 0;
            if (n_qw > 1 && ($random(seed) & 1)) begin
                split = 1 + ($unsigned($random(seed)) % (n_qw - 1));
            end
            if (split != 0) begin
                send_frame(CPL_FMT_TYPE, CPL_STATUS_SC, split, good_qw, 1'b1);
                send_frame(CPL_FMT_TYPE, CPL_STATUS_SC, n_qw - split, good_qw, 1'b1);
            end else begin
                send_frame(CPL_FMT_TYPE, CPL_STATUS_SC, n_qw, good_qw, 1'b1);
            end
            if (!junk_done) begin
                junk_done = 1'b1;
                send_frame(7'b10_00000, CPL_STATUS_SC, 3, 5000, 1'b0);  // memory write
                send_frame(CPL_FMT_TYPE, 3'b001, 4, 6000, 1'b0);        // unsupported request
            end
        end
    end

    // back-pressure gaps and ring consumer
    always @(posedge trn_clk) begin
        if (reset_n) begin
            trn_rdst_rdy_n <= (($random(seed) & 3) == 0);
            if (($random(seed) & 1) && commited_rd_addr != commited_wr_addr) begin
                commited_rd_addr <= commited_rd_addr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // output checks
    ////////////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin
        if (reset_n && wr_en) begin
            if (exp_data.size() == 0) begin
                abort_run("ring write with no payload outstanding");
            end else begin
                exp_word = exp_data.pop_front();
                assert (wr_addr == BUF_AW'(writes_seen))
                    else report_mismatch("wr_addr", 64'(wr_addr), 64'(BUF_AW'(writes_seen)));
                assert (wr_data == exp_word) else report_mismatch("wr_data", wr_data, exp_word);
                writes_seen++;
            end
        end
    end

    always @(posedge trn_clk) begin
        if (reset_n && page_free) begin
            assert (issued == page_size[cur_page])
                else report_mismatch("requested qwords", 64'(issued), 64'(page_size[cur_page]));
            frees++;
        end
    end

    always @(posedge trn_clk) begin
        if (reset_n && notify && !notify_ack) begin
            assert (notification_message == page_base[cur_page])
                else report_mismatch("notification_message", notification_message,
                                     page_base[cur_page]);
            assert (writes_seen >= page_target)
                else abort_run("notify raised before the page data was written");
            notes++;
            notify_ack <= 1'b1;
        end else begin
            notify_ack <= 1'b0;
        end
    end

    always @(posedge trn_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) abort_run("timeout waiting for the pages to complete");
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        trn_clk          = 1'b0;
        reset_n          = 1'b0;
        trn_rd           = '0;
        trn_rsof_n       = 1'b1;
        trn_reof_n       = 1'b1;
        trn_rsrc_rdy_n   = 1'b1;
        trn_rdst_rdy_n   = 1'b0;
        page_valid       = 1'b0;
        page_addr        = '0;
        page_qwords      = '0;
        read_chunk_ack   = 1'b0;
        notify_ack       = 1'b0;
        commited_rd_addr = '0;
        issued           = '0;
        repeat (2) @(posedge trn_clk);
        reset_n <= 1'b1;
        for (int p = 0; p < NUM_PAGES; p++) begin
            @(posedge trn_clk);
            cur_page    = p;
            issued      = '0;
            page_target += int'(page_size[p]);
            page_valid  <= 1'b1;
            page_addr   <= page_base[p];
            page_qwords <= page_size[p];
            while (!read_chunk) @(posedge trn_clk);
            page_valid <= 1'b0;
            while (notes < p + 1 || frees < p + 1) @(posedge trn_clk);
        end
        repeat (20) @(posedge trn_clk);
        if (exp_data.size() != 0 || writes_seen != TOTAL_QW || notes != NUM_PAGES
                || frees != NUM_PAGES) begin
            abort_run($sformatf("end counts wrong: %0d writes, %0d notifies, %0d page frees",
                                writes_seen, notes, frees));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== dma_rx_top.f ====
hw/dma_rx_pkg.sv
hw/chunk_if.sv
hw/dma_rx_ctrl.sv
hw/chunk_sizer.sv
hw/cpl_writer.sv
hw/dma_rx_top.sv
bench/dma_rx_assert.sv
bench/dma_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_rx_tb
FILELIST  ?= dma_rx_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
